/* files.f */
common/xalu_pkg.sv
xalu/xalu_ctrl.sv
xalu/xalu_mult.sv
xalu/xalu_div.sv
source/hilo_regs.sv
source/xalu_top.sv
verif/xalu_checker.sv
verif/xalu_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f files.f --top-module xalu_tb -Mdir obj_dir -o xalu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/xalu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
  exit 0
fi
echo "pass message not found"
exit 1

/* verif/xalu_tb.sv */
`timescale 1ns/1ps

module xalu_tb;
  import xalu_pkg::*;

  localparam time CLK_PERIOD    = 100;
  localparam int  N_MOVES       = 8;
  localparam int  N_MULS        = 24;
  localparam int  N_DIVS        = 24;
  localparam int  N_DIRECTED    = 16;
  localparam int  N_REQ         = 2 * N_MOVES + N_MULS + N_DIVS + N_DIRECTED;
  localparam int  WORST_CYCLES  = DIV_STEPS + 4;  // slowest divide incl. write
  localparam time WATCHDOG_TIME = (N_REQ + 8) * WORST_CYCLES * CLK_PERIOD;

  logic            clk;
  logic            reset;
  xalu_req_t       req;
  logic            flush;
  logic [XLEN-1:0] hi;
  logic [XLEN-1:0] lo;
  logic            busy;
  logic [31:0]     rng_state;
  int              checks;
  int              value_errs;
  int              other_errs;

  xalu_top UUT (
    .clk     (clk),
    .reset   (reset),
    .req_i   (req),
    .flush_i (flush),
    .hi_o    (hi),
    .lo_o    (lo),
    .busy_o  (busy)
  );

  xalu_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .req_i        (req),
    .flush_i      (flush),
    .hi_i         (hi),
    .lo_i         (lo),
    .busy_i       (busy),
    .checks_o     (checks),
    .value_errs_o (value_errs),
    .other_errs_o (other_errs)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v         = rng_state;
  endtask

  // hold the request until the edge that accepts it
  task automatic send_request(input xalu_op_t op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
    req <= {op, a, b};
    do begin
      @(posedge clk);
    end while (busy || flush);
    req.op <= NOP;
  endtask

  task automatic wait_idle();
    @(posedge clk);
    while (busy) begin
      @(posedge clk);
    end
  endtask

  task automatic exercise_moves();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < N_MOVES; i++) begin
      next_rand(a);
      next_rand(b);
      send_request(MTHI, a, b);
      next_rand(a);
      send_request(MTLO, a, b);
    end
  endtask

  task automatic multiply_sweep();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < N_MULS; i++) begin
      next_rand(a);
      next_rand(b);
      send_request((i % 3 == 0) ? MULT : ((i % 3 == 1) ? MULTU : MUL), a, b);
    end
    send_request(MULT, 32'h8000_0000, 32'h8000_0000);
    send_request(MULTU, 32'hffff_ffff, 32'hffff_ffff);
    send_request(MUL, 32'hffff_ffff, 32'd5);
  endtask

  task automatic divide_sweep();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [31:0]     r;
    for (int i = 0; i < N_DIVS; i++) begin
      next_rand(a);
      next_rand(b);
      next_rand(r);
      b = b >> r[4:0];                            // spread the quotient sizes
      if (r[5]) begin
        b = -b;
      end
      send_request(r[6] ? DIV : DIVU, a, b);
    end
    send_request(DIV, 32'h8000_0000, 32'hffff_ffff);
    send_request(DIV, -32'd7, 32'd2);
    send_request(DIV, 32'd7, -32'd2);
    send_request(DIV, -32'd7, -32'd2);
    send_request(DIVU, 32'hffff_ffff, 32'd3);
    send_request(DIV, 32'h1234_5678, 32'd0);      // divide by zero
    send_request(DIV, 32'hf000_0001, 32'd0);
    send_request(DIVU, 32'hdead_beef, 32'd0);
  endtask

  task automatic flush_blocking();
    logic [XLEN-1:0] v;
    next_rand(v);
    flush <= 1'b1;
    req   <= {MTHI, v, v};
    repeat (3) @(posedge clk);
    req   <= {DIV, v, 32'd3};
    repeat (3) @(posedge clk);
    req.op <= NOP;
    flush  <= 1'b0;
    @(posedge clk);
    send_request(DIVU, v, 32'd7);
    next_rand(v);
    flush <= 1'b1;                                // running divide keeps going
    repeat (5) @(posedge clk);
    flush <= 1'b0;
    send_request(MTLO, v, v);                     // held until the divide is done
    wait_idle();
  endtask

  initial begin
    reset     = 1'b1;
    flush     = 1'b0;
    req       = {NOP, {XLEN{1'b0}}, {XLEN{1'b0}}};
    rng_state = 32'd96;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    exercise_moves();
    multiply_sweep();
    divide_sweep();
    wait_idle();
    flush_blocking();
    repeat (4) @(posedge clk);
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0 && checks > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired at %0t, the run did not finish in time", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* verif/xalu_checker.sv */
`timescale 1ns/1ps

module xalu_checker (
  input  logic                      clk,
  input  logic                      reset,
  input  xalu_pkg::xalu_req_t       req_i,
  input  logic                      flush_i,
  input  logic [xalu_pkg::XLEN-1:0] hi_i,
  input  logic [xalu_pkg::XLEN-1:0] lo_i,
  input  logic                      busy_i,
  output int                        checks_o,
  output int                        value_errs_o,
  output int                        other_errs_o
);
  import xalu_pkg::*;

  int        n_checks      = 0;
  int        n_value_errs  = 0;
  int        n_other_errs  = 0;
  int        cyc           = 0;
  int        acc_cyc       = 0;
  logic      busy_last     = 1'b0;
  logic      long_acc_last = 1'b0;
  logic      pend_mul      = 1'b0;
  logic      pend_valid    = 1'b0;
  xalu_res_t exp_q         = '0;                  // what hi/lo must show now
  xalu_res_t pend_q        = '0;                  // result of the running op

  // expected HI/LO of a long operation
  function automatic xalu_res_t ref_result(input xalu_op_t op, input logic [XLEN-1:0] a,
                                           input logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] sprod;
    logic [2*XLEN-1:0]        uprod;
    logic signed [XLEN-1:0]   sa;
    logic signed [XLEN-1:0]   sb;
    xalu_res_t                r;
    sa    = a;
    sb    = b;
    sprod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
    uprod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    r     = '0;
    case (op)
      MULT, MUL: begin
        r.hi = sprod[2*XLEN-1:XLEN];
        r.lo = sprod[XLEN-1:0];
      end
      MULTU: begin
        r.hi = uprod[2*XLEN-1:XLEN];
        r.lo = uprod[XLEN-1:0];
      end
      DIV: begin
        if (b == '0) begin
          r.lo = '1;                              // divide by zero
          r.hi = a;
        end else if (a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
          r.lo = a;                               // overflow case
          r.hi = '0;
        end else begin
          r.lo = sa / sb;                         // truncates toward zero
          r.hi = sa % sb;
        end
      end
      DIVU: begin
        r.lo = (b == '0) ? '1 : a / b;
        r.hi = (b == '0) ? a : a % b;
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
    n_checks++;
    if (got !== expected) begin
      n_value_errs++;
      $display("Error: %s = %h, expected %h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic report(input string msg);
    n_other_errs++;
    $display("%s at %0t", msg, $time);
  endtask

  always @(posedge clk) begin : compare_proc
    int   lat;
    logic accept;
    if (reset) begin
      exp_q         = '0;
      busy_last     = 1'b0;
      long_acc_last = 1'b0;
      pend_valid    = 1'b0;
    end else begin
      cyc++;
      if (busy_i !== 1'b0 && busy_i !== 1'b1) begin
        report("busy_o is unknown");
      end else if (long_acc_last && !busy_i) begin
        report("busy_o did not rise after a long operation was accepted");
      end else if (!long_acc_last && !busy_last && busy_i) begin
        report("busy_o rose without an accepted long operation");
      end
      if (busy_last && busy_i === 1'b0) begin     // busy fell at the last edge
        lat = cyc - acc_cyc - 1;
        if (!pend_valid) begin
          report("busy_o fell with no operation running");
        end else begin
          if (pend_mul && lat != MULT_STAGES + 2) begin
            report($sformatf("multiply took %0d cycles instead of %0d", lat, MULT_STAGES + 2));
          end else if (!pend_mul && lat > DIV_STEPS + 4) begin
            report($sformatf("divide took %0d cycles, more than allowed", lat));
          end
          exp_q      = pend_q;
          pend_valid = 1'b0;
        end
      end
      compare_value("hi_o", hi_i, exp_q.hi);
      compare_value("lo_o", lo_i, exp_q.lo);
      accept        = (req_i.op != NOP) && (busy_i === 1'b0) && !flush_i;
      long_acc_last = 1'b0;
      if (accept) begin
        case (req_i.op)
          MTHI: exp_q.hi = req_i.a;               // visible after this edge
          MTLO: exp_q.lo = req_i.a;
          default: begin
            pend_q        = ref_result(req_i.op, req_i.a, req_i.b);
            pend_mul      = (req_i.op == MULT) || (req_i.op == MULTU) || (req_i.op == MUL);
            pend_valid    = 1'b1;
            acc_cyc       = cyc;
            long_acc_last = 1'b1;
          end
        endcase
      end
      busy_last = (busy_i === 1'b1);
    end
  end

  assign checks_o     = n_checks;
  assign value_errs_o = n_value_errs;
  assign other_errs_o = n_other_errs;

endmodule

/* source/xalu_top.sv */
`timescale 1ns/1ps

module xalu_top (
  input  logic                      clk,
  input  logic                      reset,
  input  xalu_pkg::xalu_req_t       req_i,
  input  logic                      flush_i,
  output logic [xalu_pkg::XLEN-1:0] hi_o,
  output logic [xalu_pkg::XLEN-1:0] lo_o,
  output logic                      busy_o
);
  import xalu_pkg::*;

  logic              mul_start;
  logic              mul_signed;
  logic              div_start;
  logic              div_signed;
  logic [XLEN-1:0]   opa;
  logic [XLEN-1:0]   opb;
  logic              mul_done;
  logic [PROD_W-1:0] mul_res;
  logic              div_done;
  logic [XLEN-1:0]   quo;
  logic [XLEN-1:0]   rem;
  logic              res_we;
  logic              move_hi_we;
  logic              move_lo_we;
  xalu_res_t         res;
  logic [XLEN-1:0]   move_val;

  xalu_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .req_i        (req_i),
    .flush_i      (flush_i),
    .busy_o       (busy_o),
    .mul_start_o  (mul_start),
    .mul_signed_o (mul_signed),
    .div_start_o  (div_start),
    .div_signed_o (div_signed),
    .opa_o        (opa),
    .opb_o        (opb),
    .mul_done_i   (mul_done),
    .mul_res_i    (mul_res),
    .div_done_i   (div_done),
    .quo_i        (quo),
    .rem_i        (rem),
    .res_we_o     (res_we),
    .move_hi_we_o (move_hi_we),
    .move_lo_we_o (move_lo_we),
    .res_o        (res),
    .move_val_o   (move_val)
  );

  xalu_mult u_mult (
    .clk      (clk),
    .reset    (reset),
    .start_i  (mul_start),
    .signed_i (mul_signed),
    .a_i      (opa),
    .b_i      (opb),
    .done_o   (mul_done),
    .prod_o   (mul_res)
  );

  xalu_div u_div (
    .clk      (clk),
    .reset    (reset),
    .start_i  (div_start),
    .signed_i (div_signed),
    .a_i      (opa),
    .b_i      (opb),
    .done_o   (div_done),
    .quo_o    (quo),
    .rem_o    (rem)
  );

  hilo_regs u_hilo (
    .clk          (clk),
    .reset        (reset),
    .res_we_i     (res_we),
    .res_i        (res),
    .move_hi_we_i (move_hi_we),
    .move_lo_we_i (move_lo_we),
    .move_val_i   (move_val),
    .hi_o         (hi_o),
    .lo_o         (lo_o)
  );

endmodule

/* source/hilo_regs.sv */
`timescale 1ns/1ps

module hilo_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      res_we_i,
  input  xalu_pkg::xalu_res_t       res_i,
  input  logic                      move_hi_we_i,
  input  logic                      move_lo_we_i,
  input  logic [xalu_pkg::XLEN-1:0] move_val_i,
  output logic [xalu_pkg::XLEN-1:0] hi_o,
  output logic [xalu_pkg::XLEN-1:0] lo_o
);
  import xalu_pkg::*;

  logic [XLEN-1:0] hi_q;
  logic [XLEN-1:0] lo_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      hi_q <= '0;
      lo_q <= '0;
    end else if (res_we_i) begin
      hi_q <= res_i.hi;                           // datapath result wins
      lo_q <= res_i.lo;
    end else begin
      if (move_hi_we_i) begin
        hi_q <= move_val_i;
      end
      if (move_lo_we_i) begin
        lo_q <= move_val_i;
      end
    end
  end

  assign hi_o = hi_q;
  assign lo_o = lo_q;

endmodule

/* xalu/xalu_div.sv */
`timescale 1ns/1ps

module xalu_div (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start_i,
  input  logic                      signed_i,
  input  logic [xalu_pkg::XLEN-1:0] a_i,
  input  logic [xalu_pkg::XLEN-1:0] b_i,
  output logic                      done_o,
  output logic [xalu_pkg::XLEN-1:0] quo_o,
  output logic [xalu_pkg::XLEN-1:0] rem_o
);
  import xalu_pkg::*;

  typedef enum logic {
    DIV_IDLE,
    DIV_RUN
  } div_state_t;

  div_state_t           state_q;
  logic [DIV_CNT_W-1:0] cnt_q;
  logic                 done_q;
  logic [XLEN-1:0]      quo_q;                    // dividend shifts out, quotient in
  logic [XLEN-1:0]      rem_q;
  logic [XLEN-1:0]      dvsr_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;
  logic [XLEN-1:0]      a_mag;
  logic [XLEN-1:0]      b_mag;
  logic [XLEN:0]        trial;
  logic [XLEN:0]        diff;
  logic                 fits;
  logic                 div_zero;

  assign a_mag    = (signed_i && a_i[XLEN-1]) ? -a_i : a_i;
  assign b_mag    = (signed_i && b_i[XLEN-1]) ? -b_i : b_i;
  assign div_zero = (b_i == '0);

  // one restoring step
  assign trial = {rem_q, quo_q[XLEN-1]};
  assign diff  = trial - {1'b0, dvsr_q};
  assign fits  = (trial >= {1'b0, dvsr_q});

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        DIV_IDLE: begin
          if (start_i && div_zero) begin
            done_q <= 1'b1;                       // skip the iterations
          end else if (start_i) begin
            state_q <= DIV_RUN;
            cnt_q   <= DIV_CNT_W'(DIV_STEPS - 1);
          end
        end
        DIV_RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0) begin
            state_q <= DIV_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == DIV_IDLE && start_i) begin
      dvsr_q <= b_mag;
      if (div_zero) begin
        quo_q     <= '1;                          // all ones, remainder is a
        rem_q     <= a_i;
        neg_quo_q <= 1'b0;
        neg_rem_q <= 1'b0;
      end else begin
        quo_q     <= a_mag;
        rem_q     <= '0;
        neg_quo_q <= signed_i && (a_i[XLEN-1] ^ b_i[XLEN-1]);
        neg_rem_q <= signed_i && a_i[XLEN-1];     // remainder follows dividend
      end
    end else if (state_q == DIV_RUN) begin
      rem_q <= fits ? diff[XLEN-1:0] : trial[XLEN-1:0];
      quo_q <= {quo_q[XLEN-2:0], fits};
    end
  end

  // sign fix on the magnitudes
  assign quo_o  = neg_quo_q ? -quo_q : quo_q;
  assign rem_o  = neg_rem_q ? -rem_q : rem_q;
  assign done_o = done_q;

endmodule

/* xalu/xalu_mult.sv */
`timescale 1ns/1ps

module xalu_mult (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start_i,
  input  logic                        signed_i,
  input  logic [xalu_pkg::XLEN-1:0]   a_i,
  input  logic [xalu_pkg::XLEN-1:0]   b_i,
  output logic                        done_o,
  output logic [xalu_pkg::PROD_W-1:0] prod_o
);
  import xalu_pkg::*;

  // 33-bit operands cover both signed and unsigned 32-bit ranges
  logic signed [XLEN:0]     a_ext_q;
  logic signed [XLEN:0]     b_ext_q;
  logic signed [2*XLEN+1:0] prod_full;
  logic [PROD_W-1:0]        prod_q [1:MULT_STAGES-1];
  logic [MULT_STAGES-1:0]   vld_q;

  // stage 0 holds the extended operands
  always_ff @(posedge clk) begin
    a_ext_q <= {signed_i & a_i[XLEN-1], a_i};
    b_ext_q <= {signed_i & b_i[XLEN-1], b_i};
  end

  assign prod_full = a_ext_q * b_ext_q;           // signed 33x33

  // product enters stage 1, then walks down the pipe
  always_ff @(posedge clk) begin
    prod_q[1] <= prod_full[PROD_W-1:0];
    for (int i = 2; i < MULT_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[MULT_STAGES-2:0], start_i}; // tracks each item in flight
    end
  end

  assign done_o = vld_q[MULT_STAGES-1];
  assign prod_o = prod_q[MULT_STAGES-1];

endmodule

/* xalu/xalu_ctrl.sv */
`timescale 1ns/1ps

module xalu_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  xalu_pkg::xalu_req_t         req_i,
  input  logic                        flush_i,
  output logic                        busy_o,
  output logic                        mul_start_o,
  output logic                        mul_signed_o,
  output logic                        div_start_o,
  output logic                        div_signed_o,
  output logic [xalu_pkg::XLEN-1:0]   opa_o,
  output logic [xalu_pkg::XLEN-1:0]   opb_o,
  input  logic                        mul_done_i,
  input  logic [xalu_pkg::PROD_W-1:0] mul_res_i,
  input  logic                        div_done_i,
  input  logic [xalu_pkg::XLEN-1:0]   quo_i,
  input  logic [xalu_pkg::XLEN-1:0]   rem_i,
  output logic                        res_we_o,
  output logic                        move_hi_we_o,
  output logic                        move_lo_we_o,
  output xalu_pkg::xalu_res_t         res_o,
  output logic [xalu_pkg::XLEN-1:0]   move_val_o
);
  import xalu_pkg::*;

  logic            accept;
  logic            busy_q;
  logic            mul_start_q;
  logic            div_start_q;
  logic            signed_q;
  logic            res_we_q;
  logic            mul_hit;
  logic            div_hit;
  xalu_op_t        op_q;
  logic [XLEN-1:0] opa_q;
  logic [XLEN-1:0] opb_q;
  xalu_res_t       res_q;

  assign accept = (req_i.op != NOP) && !busy_q && !flush_i;

  // moves go straight to the register pair, no busy phase
  assign move_hi_we_o = accept && (req_i.op == MTHI);
  assign move_lo_we_o = accept && (req_i.op == MTLO);
  assign move_val_o   = req_i.a;

  // only honour the done of the datapath that was launched
  assign mul_hit = mul_done_i && is_mul_op(op_q);
  assign div_hit = div_done_i && is_div_op(op_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q      <= 1'b0;
      mul_start_q <= 1'b0;
      div_start_q <= 1'b0;
      res_we_q    <= 1'b0;
      op_q        <= NOP;
    end else begin
      mul_start_q <= accept && is_mul_op(req_i.op); // one-cycle launch
      div_start_q <= accept && is_div_op(req_i.op);
      res_we_q    <= mul_hit || div_hit;
      if (accept && is_long_op(req_i.op)) begin
        busy_q <= 1'b1;
        op_q   <= req_i.op;
      end else if (res_we_q) begin
        busy_q <= 1'b0;                             // drops with the HI/LO write
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opa_q    <= req_i.a;
      opb_q    <= req_i.b;
      signed_q <= is_signed_op(req_i.op);
    end
    if (mul_hit) begin
      res_q.hi <= mul_res_i[PROD_W-1:XLEN];
      res_q.lo <= mul_res_i[XLEN-1:0];
    end else if (div_hit) begin
      res_q.hi <= rem_i;                            // remainder to HI
      res_q.lo <= quo_i;                            // quotient to LO
    end
  end

  assign busy_o       = busy_q;
  assign mul_start_o  = mul_start_q;
  assign div_start_o  = div_start_q;
  assign mul_signed_o = signed_q;
  assign div_signed_o = signed_q;
  assign opa_o        = opa_q;
  assign opb_o        = opb_q;
  assign res_we_o     = res_we_q;
  assign res_o        = res_q;

endmodule

/* common/xalu_pkg.sv */
package xalu_pkg;

  localparam int XLEN        = 32;
  localparam int PROD_W      = 2 * XLEN;          // full product width
  localparam int MULT_STAGES = 4;                 // register stages in multiplier
  localparam int DIV_STEPS   = XLEN;              // one quotient bit per step
  localparam int DIV_CNT_W   = $clog2(DIV_STEPS);

  // operation codes as produced by the CPU decoder
  typedef enum logic [2:0] {
    NOP   = 3'd0,
    MULT  = 3'd1,
    MULTU = 3'd2,
    MUL   = 3'd3,
    DIV   = 3'd4,
    DIVU  = 3'd5,
    MTHI  = 3'd6,
    MTLO  = 3'd7
  } xalu_op_t;

  typedef struct packed {
    xalu_op_t          op;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
  } xalu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   hi;
    logic [XLEN-1:0]   lo;
  } xalu_res_t;

  function automatic logic is_mul_op(input xalu_op_t op);
    return (op == MULT) || (op == MULTU) || (op == MUL);
  endfunction

  function automatic logic is_div_op(input xalu_op_t op);
    return (op == DIV) || (op == DIVU);
  endfunction

  // MUL uses the signed multiplier, same as MULT
  function automatic logic is_signed_op(input xalu_op_t op);
    return (op == MULT) || (op == MUL) || (op == DIV);
  endfunction

  function automatic logic is_long_op(input xalu_op_t op);
    return is_mul_op(op) || is_div_op(op);
  endfunction

endpackage
